//--- hw/ddr3_pkg.sv
package ddr3_pkg;

    ////////////////////
    // Geometry of one x8 part
    localparam int ROW_W = 15;  // A14..A0
    localparam int COL_W = 10;  // A9..A0 on column commands
    localparam int BA_W  = 3;   // Eight banks
    localparam int DQ_W  = 8;

    localparam int BURST_LEN = 8;                 // BL8 only
    localparam int BURST_W   = BURST_LEN * DQ_W;  // One whole burst

    ////////////////////
    // Commands the sequencer can place on the bus
    typedef enum logic [2:0] {
        NOP,
        ACT,   // Open a row
        WR,
        RD,
        PRE,   // Close one bank, or all with A10
        REF,
        ZQCL   // Long calibration after reset
    } cmd_e;

    // Column commands read A14..A0 this way
    typedef struct packed {
        logic [1:0]       a13_14;
        logic             bl8;     // A12, high for BL8 on the fly
        logic             a11;
        logic             a10;     // Auto precharge on WR/RD, all banks on PRE
        logic [COL_W-1:0] column;
    } col_view_t;

    // Same address pins, decoded by the command that goes with them
    typedef union packed {
        logic [ROW_W-1:0] row_addr;  // ACT
        col_view_t        col_addr;  // WR, RD, PRE, ZQCL
    } dram_addr_u;

    ////////////////////
    // Port structs
    typedef struct packed {
        logic            cs_n;
        logic            ras_n;
        logic            cas_n;
        logic            we_n;
        logic [BA_W-1:0] ba;
        dram_addr_u      addr;
    } dram_cmd_t;

    typedef logic [BURST_W-1:0] burst_t;  // Beat 0 in bits 7:0

    typedef struct packed {
        logic             is_write;  // Else read
        logic [BA_W-1:0]  ba;
        logic [ROW_W-1:0] row;
        dram_addr_u       col;       // Column view
        burst_t           wdata;
    } host_req_t;

    // Chip deselected, acts as NOP
    localparam dram_cmd_t DESELECT = dram_cmd_t'({4'b1111, {(BA_W + ROW_W){1'b0}}});

endpackage

//--- hw/ddr3_init_seq.sv
`timescale 1ns/1ps

module ddr3_init_seq #(
    parameter int RESET_CYCLES = 10
) (
    input  logic                CLK,
    input  logic                rst,
    output logic                dram_reset_n,
    output ddr3_pkg::dram_cmd_t init_cmd,
    output logic                init_done
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    typedef enum logic [1:0] {
        S_HOLD,  // RESET# low
        S_ZQ,    // Single ZQCL slot
        S_DONE
    } init_state_e;

    init_state_e      state;
    logic [CNT_W-1:0] hold_cnt;  // Cycles spent in S_HOLD

    ////////////////////
    // Sequence
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state    <= S_HOLD;
            hold_cnt <= '0;
        end else begin
            case (state)
                S_HOLD: begin
                    if (hold_cnt == CNT_W'(RESET_CYCLES - 1)) begin
                        state <= S_ZQ;  // Last low cycle
                    end
                    hold_cnt <= hold_cnt + 1'b1;
                end
                S_ZQ: begin
                    state <= S_DONE;  // ZQCL lasts one cycle
                end
                default: begin
                    state <= S_DONE;  // Terminal until next rst
                end
            endcase
        end
    end

    assign dram_reset_n = (state != S_HOLD);  // Released with the ZQ slot
    assign init_done    = (state == S_DONE);

    // ZQCL is CS/WE low, RAS/CAS high, A10 high
    always_comb begin
        init_cmd = ddr3_pkg::DESELECT;
        if (state == S_ZQ) begin
            init_cmd.cs_n              = 1'b0;
            init_cmd.we_n              = 1'b0;
            init_cmd.addr.col_addr.a10 = 1'b1;  // Long form
        end
    end

    // Calibration runs once per rst
    a_done_sticky: assert property (@(posedge CLK) disable iff (rst)
        init_done |=> init_done);

endmodule

//--- hw/ddr3_access_fsm.sv
`timescale 1ns/1ps

module ddr3_access_fsm #(
    parameter int T_RCD = 10,   // ACT to column command, at least 2
    parameter int T_RFC = 103,  // NOP cycles after REF
    parameter int WL    = 7,    // WR to first beat, at least 2
    parameter int RL    = 5     // RD to first beat, at least 2
) (
    input  logic                CLK,
    input  logic                rst,
    input  ddr3_pkg::dram_cmd_t init_cmd,
    input  logic                init_done,
    input  logic                acc_req,
    input  ddr3_pkg::host_req_t acc,
    output logic                acc_ack,
    input  logic                ref_req,
    output logic                ref_ack,
    output ddr3_pkg::dram_cmd_t cmd,
    output logic                burst_start,
    output logic                burst_write,
    output ddr3_pkg::burst_t    wdata,
    input  ddr3_pkg::burst_t    rdata_in,
    output ddr3_pkg::burst_t    rdata
);

    // Longest wait the shared counter has to hold
    localparam int MAX_A = (T_RFC > T_RCD) ? T_RFC : T_RCD;
    localparam int MAX_B = (WL > RL) ? WL : RL;
    localparam int MAX_C = (MAX_A > MAX_B) ? MAX_A : MAX_B;
    localparam int MAX_T = (MAX_C > ddr3_pkg::BURST_LEN) ? MAX_C : ddr3_pkg::BURST_LEN;
    localparam int CNT_W = $clog2(MAX_T + 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_REF,       // REF on the bus
        S_REF_WAIT,  // tRFC
        S_ACT,       // ACT on the bus
        S_BANK_ACT,  // Rest of tRCD
        S_COL,       // WR or RD on the bus
        S_LAT,       // Rest of WL or RL
        S_BURST,     // Eight beats on DQ
        S_PRE,
        S_RELEASE    // Ack high, wait for req low
    } acc_state_e;

    acc_state_e          state;
    acc_state_e          state_d;
    logic [CNT_W-1:0]    cnt;         // Shared down-counter
    logic [CNT_W-1:0]    cnt_d;
    logic [CNT_W-1:0]    lat_load;
    ddr3_pkg::cmd_e      op_d;        // Command for the next cycle
    ddr3_pkg::dram_cmd_t cmd_d;
    ddr3_pkg::host_req_t req_q;       // Held for the whole access
    ddr3_pkg::host_req_t src;         // Address source for the encoder
    logic                accept;
    logic                release_hs;

    assign lat_load    = req_q.is_write ? CNT_W'(WL - 2) : CNT_W'(RL - 2);
    assign burst_start = (state == S_LAT) && (cnt == '0);  // One cycle before beat 0
    assign burst_write = req_q.is_write;
    assign wdata       = req_q.wdata;

    // Falling edge of whichever request is being acknowledged
    assign release_hs = (state == S_RELEASE) &&
                        ((acc_ack && !acc_req) || (ref_ack && !ref_req));

    ////////////////////
    // Next state
    always_comb begin
        state_d = state;
        cnt_d   = (cnt != '0) ? cnt - 1'b1 : cnt;
        op_d    = ddr3_pkg::NOP;
        accept  = 1'b0;
        case (state)
            S_IDLE: begin
                if (init_done && ref_req) begin
                    state_d = S_REF;  // Refresh wins a tie
                    op_d    = ddr3_pkg::REF;
                end else if (init_done && acc_req) begin
                    state_d = S_ACT;
                    op_d    = ddr3_pkg::ACT;
                    accept  = 1'b1;
                end
            end
            S_REF: begin
                state_d = S_REF_WAIT;
                cnt_d   = CNT_W'(T_RFC - 1);
            end
            S_REF_WAIT: begin
                if (cnt == '0) begin
                    state_d = S_RELEASE;
                end
            end
            S_ACT: begin
                state_d = S_BANK_ACT;
                cnt_d   = CNT_W'(T_RCD - 2);  // ACT slot counts toward tRCD
            end
            S_BANK_ACT: begin
                if (cnt == '0) begin
                    state_d = S_COL;
                    if (req_q.is_write) begin
                        op_d = ddr3_pkg::WR;
                    end else begin
                        op_d = ddr3_pkg::RD;
                    end
                end
            end
            S_COL: begin
                state_d = S_LAT;
                cnt_d   = lat_load;
            end
            S_LAT: begin
                if (cnt == '0) begin
                    state_d = S_BURST;
                    cnt_d   = CNT_W'(ddr3_pkg::BURST_LEN - 1);
                end
            end
            S_BURST: begin
                if (cnt == '0) begin
                    state_d = S_PRE;
                    op_d    = ddr3_pkg::PRE;
                end
            end
            S_PRE: begin
                state_d = S_RELEASE;
            end
            S_RELEASE: begin
                if (release_hs) begin
                    state_d = S_IDLE;
                end
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    ////////////////////
    // Command encoder, row or column view of the address
    assign src = (state == S_IDLE) ? acc : req_q;  // ACT leaves before req_q loads

    always_comb begin
        cmd_d = ddr3_pkg::DESELECT;
        case (op_d)
            ddr3_pkg::ACT: begin
                cmd_d.cs_n          = 1'b0;
                cmd_d.ras_n         = 1'b0;
                cmd_d.ba            = src.ba;
                cmd_d.addr.row_addr = src.row;
            end
            ddr3_pkg::WR, ddr3_pkg::RD: begin
                cmd_d.cs_n              = 1'b0;
                cmd_d.cas_n             = 1'b0;
                cmd_d.we_n              = (op_d == ddr3_pkg::RD);
                cmd_d.ba                = src.ba;
                cmd_d.addr.col_addr     = src.col.col_addr;
                cmd_d.addr.col_addr.bl8 = 1'b1;  // Burst fixed at 8
            end
            ddr3_pkg::PRE: begin
                cmd_d.cs_n              = 1'b0;
                cmd_d.ras_n             = 1'b0;
                cmd_d.we_n              = 1'b0;
                cmd_d.ba                = src.ba;
                cmd_d.addr.col_addr.a10 = src.col.col_addr.a10;  // High closes all banks
            end
            ddr3_pkg::REF: begin
                cmd_d.cs_n  = 1'b0;
                cmd_d.ras_n = 1'b0;
                cmd_d.cas_n = 1'b0;
            end
            default: begin
                cmd_d = ddr3_pkg::DESELECT;  // NOP
            end
        endcase
    end

    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            state   <= S_IDLE;
            cnt     <= '0;
            cmd     <= ddr3_pkg::DESELECT;
            acc_ack <= 1'b0;
            ref_ack <= 1'b0;
        end else begin
            state <= state_d;
            cnt   <= cnt_d;
            cmd   <= init_done ? cmd_d : init_cmd;  // Init owns the bus first
            if (state == S_PRE) begin
                acc_ack <= 1'b1;
            end
            if ((state == S_REF_WAIT) && (cnt == '0)) begin
                ref_ack <= 1'b1;
            end
            if (release_hs) begin
                acc_ack <= 1'b0;
                ref_ack <= 1'b0;
            end
        end
    end

    // Request and read data
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_q <= acc;
        end
        if (state == S_PRE) begin
            rdata <= rdata_in;  // Last beat landed at the PRE edge
        end
    end

    ////////////////////
    // Handshake checks
    a_acc_ack_req: assert property (@(posedge CLK) disable iff (rst)
        $rose(acc_ack) |-> acc_req);
    a_ref_ack_req: assert property (@(posedge CLK) disable iff (rst)
        $rose(ref_ack) |-> ref_req);
    a_one_ack: assert property (@(posedge CLK) disable iff (rst)
        !(acc_ack && ref_ack));

endmodule

//--- hw/ddr3_dq_burst.sv
`timescale 1ns/1ps

module ddr3_dq_burst (
    input  logic                      CLK,
    input  logic                      rst,
    input  logic                      burst_start,
    input  logic                      burst_write,
    input  ddr3_pkg::burst_t          wdata,
    input  logic [ddr3_pkg::DQ_W-1:0] dq_in,
    output logic [ddr3_pkg::DQ_W-1:0] dq_out,
    output logic                      dq_oe,
    output logic                      dqs,
    output ddr3_pkg::burst_t          rdata
);

    localparam int BEAT_W = $clog2(ddr3_pkg::BURST_LEN);

    logic                      busy;       // Beat cycles
    logic                      wr_q;       // Direction of current burst
    logic [BEAT_W-1:0]         beat;
    logic                      last_beat;
    logic [ddr3_pkg::DQ_W-1:0] beat_in;    // Byte entering at the top
    ddr3_pkg::burst_t          shift_q;

    assign last_beat = (beat == BEAT_W'(ddr3_pkg::BURST_LEN - 1));
    assign beat_in   = wr_q ? '0 : dq_in;

    ////////////////////
    // Beat counter, OE and strobe
    always_ff @(posedge CLK or posedge rst) begin
        if (rst) begin
            busy  <= 1'b0;
            wr_q  <= 1'b0;
            beat  <= '0;
            dq_oe <= 1'b0;
            dqs   <= 1'b0;
        end else if (burst_start) begin
            busy  <= 1'b1;
            wr_q  <= burst_write;
            beat  <= '0;
            dq_oe <= burst_write;
            dqs   <= burst_write;  // Rising strobe with beat 0
        end else if (busy) begin
            beat <= beat + 1'b1;
            if (last_beat) begin
                busy  <= 1'b0;
                dq_oe <= 1'b0;
                dqs   <= 1'b0;  // Postamble low
            end else begin
                dqs <= wr_q & ~dqs;  // Toggles once per beat, reads stay low
            end
        end
    end

    // One register serves both directions
    // Write shifts the low byte out, read shifts DQ in at the top
    always_ff @(posedge CLK) begin
        if (burst_start) begin
            shift_q <= burst_write ? wdata : '0;
        end else if (busy) begin
            shift_q <= {beat_in, shift_q[ddr3_pkg::BURST_W-1:ddr3_pkg::DQ_W]};
        end
    end

    assign dq_out = shift_q[ddr3_pkg::DQ_W-1:0];  // Beat i in burst cycle i
    assign rdata  = shift_q;                      // Beat 0 low after 8 shifts

    ////////////////////
    // Drivers stay off for a whole read burst
    a_read_no_oe: assert property (@(posedge CLK) disable iff (rst)
        (burst_start && !burst_write) |=> (!dq_oe) [*ddr3_pkg::BURST_LEN]);

    // Write drives exactly BURST_LEN beats
    a_write_len: assert property (@(posedge CLK) disable iff (rst)
        (burst_start && burst_write) |=> dq_oe [*ddr3_pkg::BURST_LEN] ##1 !dq_oe);

endmodule

//--- hw/ddr3_seq_top.sv
`timescale 1ns/1ps

module ddr3_seq_top #(
    parameter int RESET_CYCLES = 10,
    parameter int T_RCD        = 10,
    parameter int T_RFC        = 103,
    parameter int WL           = 7,
    parameter int RL           = 5
) (
    input  logic                      CLK,
    input  logic                      rst,
    // Host access handshake
    input  logic                      acc_req,
    input  ddr3_pkg::host_req_t       acc,
    output logic                      acc_ack,
    output ddr3_pkg::burst_t          rdata,
    // Host refresh handshake
    input  logic                      ref_req,
    output logic                      ref_ack,
    // DRAM side
    output logic                      dram_reset_n,
    output ddr3_pkg::dram_cmd_t       cmd,
    output logic [ddr3_pkg::DQ_W-1:0] dq_out,
    output logic                      dq_oe,
    input  logic [ddr3_pkg::DQ_W-1:0] dq_in,
    output logic                      dqs
);

    ddr3_pkg::dram_cmd_t init_cmd;     // Reset and ZQ phase
    logic                init_done;
    logic                burst_start;  // One-cycle pulse
    logic                burst_write;
    ddr3_pkg::burst_t    burst_wdata;
    ddr3_pkg::burst_t    burst_rdata;  // Live shift register

    ////////////////////
    // Power-up
    ddr3_init_seq #(
        .RESET_CYCLES (RESET_CYCLES)
    ) ddr3_init_seq_i (
        .CLK          (CLK),
        .rst          (rst),
        .dram_reset_n (dram_reset_n),
        .init_cmd     (init_cmd),
        .init_done    (init_done)
    );

    // Command sequencing
    ddr3_access_fsm #(
        .T_RCD (T_RCD),
        .T_RFC (T_RFC),
        .WL    (WL),
        .RL    (RL)
    ) ddr3_access_fsm_i (
        .CLK         (CLK),
        .rst         (rst),
        .init_cmd    (init_cmd),
        .init_done   (init_done),
        .acc_req     (acc_req),
        .acc         (acc),
        .acc_ack     (acc_ack),
        .ref_req     (ref_req),
        .ref_ack     (ref_ack),
        .cmd         (cmd),
        .burst_start (burst_start),
        .burst_write (burst_write),
        .wdata       (burst_wdata),
        .rdata_in    (burst_rdata),
        .rdata       (rdata)
    );

    // Data lines and strobe
    ddr3_dq_burst ddr3_dq_burst_i (
        .CLK         (CLK),
        .rst         (rst),
        .burst_start (burst_start),
        .burst_write (burst_write),
        .wdata       (burst_wdata),
        .dq_in       (dq_in),
        .dq_out      (dq_out),
        .dq_oe       (dq_oe),
        .dqs         (dqs),
        .rdata       (burst_rdata)
    );

endmodule

//--- test/ddr3_seq_tb.sv
`timescale 1ns/1ps

module ddr3_seq_tb;

    localparam int RESET_CYCLES = 10;
    localparam int T_RCD        = 10;
    localparam int T_RFC        = 103;
    localparam int WL           = 7;
    localparam int RL           = 5;
    localparam int BL           = ddr3_pkg::BURST_LEN;
    localparam int TIMEOUT      = 16 + 30 + 8 * 150;  // Reset, init, eight entries

    localparam int K_REF = 0;  // Entry kinds
    localparam int K_WR  = 1;
    localparam int K_RD  = 2;
    localparam int K_ARB = 3;  // Refresh and read raised together

    localparam int EV_CMD     = 0;  // Event kinds seen by the monitor
    localparam int EV_ACC_ACK = 1;
    localparam int EV_REF_ACK = 2;

    typedef struct {
        int                          kind;
        logic [ddr3_pkg::BA_W-1:0]   ba;
        logic [ddr3_pkg::ROW_W-1:0]  row;
        logic [ddr3_pkg::COL_W-1:0]  col;
        logic                        a10;
        ddr3_pkg::burst_t            wdata;  // Zero on a write means random
        int                          src;    // Entry a read checks against
    } entry_t;

    typedef struct {
        int                  kind;
        ddr3_pkg::dram_cmd_t c;
        int                  gap;  // Cycles since last event or -1 for any
    } exp_t;

    logic                      CLK;
    logic                      rst;
    logic                      acc_req;
    ddr3_pkg::host_req_t       acc;
    logic                      acc_ack;
    ddr3_pkg::burst_t          rdata;
    logic                      ref_req;
    logic                      ref_ack;
    logic                      dram_reset_n;
    ddr3_pkg::dram_cmd_t       cmd;
    logic [ddr3_pkg::DQ_W-1:0] dq_out;
    logic                      dq_oe;
    logic [ddr3_pkg::DQ_W-1:0] dq_in;
    logic                      dqs;

    entry_t           tbl [8];
    exp_t             exp_q [$];          // Expected bus events in order
    ddr3_pkg::burst_t mem [bit [27:0]];   // DRAM model keyed by {ba, row, col}
    logic [14:0]      open_row [8];
    bit [27:0]        key;
    ddr3_pkg::burst_t cap;                // Write burst being captured
    ddr3_pkg::burst_t rd_data;
    ddr3_pkg::burst_t cur_wdata;
    logic             cur_write;
    logic             rd_evt;
    logic             acc_req_q;          // Levels seen at the last negedge
    logic             ref_req_q;
    logic             acc_ack_q;
    logic             ref_ack_q;
    int               ncyc;
    int               last_cyc;           // Cycle of the last event or request
    int               rn_low;
    int               oe_beat;
    int               rd_timer;
    int               cyc_total;
    int               seed = 32'h35a4_9211;

    ddr3_seq_top #(
        .RESET_CYCLES (RESET_CYCLES),
        .T_RCD        (T_RCD),
        .T_RFC        (T_RFC),
        .WL           (WL),
        .RL           (RL)
    ) ddr3_seq_top_i (
        .CLK (CLK), .rst (rst), .acc_req (acc_req), .acc (acc), .acc_ack (acc_ack),
        .rdata (rdata), .ref_req (ref_req), .ref_ack (ref_ack),
        .dram_reset_n (dram_reset_n), .cmd (cmd), .dq_out (dq_out), .dq_oe (dq_oe),
        .dq_in (dq_in), .dqs (dqs)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;  // 20 ns period
    end

    ////////////////////
    // Failure and compare tasks
    task automatic stop_fail(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_cmd(input ddr3_pkg::dram_cmd_t got, exp, input string msg);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_burst(input ddr3_pkg::burst_t got, exp, input string msg);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_beat(input logic [ddr3_pkg::DQ_W-1:0] got, exp, input string msg);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp));
        end
    endtask

    task automatic check_strobe(input logic got, exp, input string msg);
        if (got !== exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, msg, got, exp));
        end
    endtask

    task automatic check_gap(input int got, exp, input string msg);
        if (got != exp) begin
            stop_fail($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, msg, got, exp));
        end
    endtask

    // DDR3 truth table on CS RAS CAS WE
    function automatic ddr3_pkg::cmd_e decode_cmd(input ddr3_pkg::dram_cmd_t c);
        if (c.cs_n) return ddr3_pkg::NOP;
        case ({c.ras_n, c.cas_n, c.we_n})
            3'b011:  return ddr3_pkg::ACT;
            3'b100:  return ddr3_pkg::WR;
            3'b101:  return ddr3_pkg::RD;
            3'b010:  return ddr3_pkg::PRE;
            3'b001:  return ddr3_pkg::REF;
            3'b110:  return ddr3_pkg::ZQCL;
            default: return ddr3_pkg::NOP;
        endcase
    endfunction

    function automatic ddr3_pkg::dram_cmd_t build_cmd(input ddr3_pkg::cmd_e op,
                                                      input logic [2:0] ba,
                                                      input logic [14:0] a);
        ddr3_pkg::dram_cmd_t c;
        c.cs_n          = 1'b0;
        c.ras_n         = !(op == ddr3_pkg::ACT || op == ddr3_pkg::PRE || op == ddr3_pkg::REF);
        c.cas_n         = !(op == ddr3_pkg::WR || op == ddr3_pkg::RD || op == ddr3_pkg::REF);
        c.we_n          = !(op == ddr3_pkg::WR || op == ddr3_pkg::PRE || op == ddr3_pkg::ZQCL);
        c.ba            = ba;
        c.addr.row_addr = a;  // Raw A14..A0
        return c;
    endfunction

    task automatic push_exp(input int kind, input ddr3_pkg::dram_cmd_t c, input int gap);
        exp_t e;
        e.kind = kind;
        e.c    = c;
        e.gap  = gap;
        exp_q.push_back(e);
    endtask

    // Pops the next expected event and checks kind, value and spacing
    task automatic take_event(input int kind, input ddr3_pkg::dram_cmd_t c);
        exp_t e;
        if (exp_q.size() == 0) stop_fail("Unexpected command or ack on the bus");
        e = exp_q.pop_front();
        if (e.kind != kind) stop_fail("Command or ack arrived out of order");
        if (kind == EV_CMD) check_cmd(c, e.c, "command bus");
        if (e.gap >= 0) check_gap(ncyc - last_cyc, e.gap, "cycles between events");
        last_cyc = ncyc;
    endtask

    ////////////////////
    // Monitor and DRAM model sample mid cycle
    always @(negedge CLK) begin
        ddr3_pkg::cmd_e op;
        op     = decode_cmd(cmd);
        ncyc   = ncyc + 1;
        rd_evt = 1'b0;
        if (!rst && !dram_reset_n) rn_low = rn_low + 1;
        if ((acc_req && !acc_req_q) || (ref_req && !ref_req_q)) last_cyc = ncyc;  // Req seen
        if (op != ddr3_pkg::NOP) begin
            take_event(EV_CMD, cmd);
            if (op == ddr3_pkg::ACT) open_row[cmd.ba] = cmd.addr.row_addr;
            if (op == ddr3_pkg::WR || op == ddr3_pkg::RD) begin
                key = {cmd.ba, open_row[cmd.ba], cmd.addr.col_addr.column};
            end
            if (op == ddr3_pkg::RD) begin
                if (!mem.exists(key)) stop_fail("Read of an address never written");
                rd_data = mem[key];
                rd_evt  = 1'b1;
            end
        end
        if (acc_ack && !acc_ack_q) take_event(EV_ACC_ACK, cmd);
        if (ref_ack && !ref_ack_q) take_event(EV_REF_ACK, cmd);
        // Strobe high on even write beats and low otherwise
        check_strobe(dqs, dq_oe && (oe_beat % 2 == 0), "DQS level");
        if (dq_oe) begin
            if (!cur_write) stop_fail("Data drivers on during a read");
            if (oe_beat >= BL) stop_fail("Write burst longer than eight beats");
            if (oe_beat == 0) check_gap(ncyc - last_cyc, WL, "WR to first write beat");
            check_beat(dq_out, cur_wdata[oe_beat*8 +: 8], "write beat");
            cap[oe_beat*8 +: 8] = dq_out;
            oe_beat = oe_beat + 1;
        end else if (oe_beat != 0) begin
            check_gap(oe_beat, BL, "write beats driven");
            mem[key] = cap;  // Burst done so store it
            oe_beat  = 0;
        end
        acc_req_q = acc_req;
        ref_req_q = ref_req;
        acc_ack_q = acc_ack;
        ref_ack_q = ref_ack;
    end

    // Read data with beat 0 driven RL cycles after RD
    always @(posedge CLK) begin
        if (rd_timer > 0) rd_timer = rd_timer + 1;
        if (rd_evt) rd_timer = 1;
        if (rd_timer >= RL && rd_timer < RL + BL) begin
            dq_in <= rd_data[(rd_timer - RL)*8 +: 8];
        end else begin
            dq_in <= '0;
            if (rd_timer >= RL + BL) rd_timer = 0;
        end
    end

    always @(posedge CLK) begin  // Watchdog
        cyc_total = cyc_total + 1;
        if (cyc_total >= TIMEOUT) stop_fail("Timeout: the DUT stopped answering requests");
    end

    ////////////////////
    // Handshake tasks
    task automatic start_access(input entry_t e, input int act_gap);
        ddr3_pkg::host_req_t r;
        r.is_write     = (e.kind == K_WR);
        r.ba           = e.ba;
        r.row          = e.row;
        r.col.row_addr = {4'b0000, e.a10, e.col};
        r.wdata        = r.is_write ? e.wdata : '0;
        cur_write      = r.is_write;
        cur_wdata      = e.wdata;
        push_exp(EV_CMD, build_cmd(ddr3_pkg::ACT, e.ba, e.row), act_gap);
        push_exp(EV_CMD, build_cmd(r.is_write ? ddr3_pkg::WR : ddr3_pkg::RD, e.ba,
                                   {4'b0010, e.a10, e.col}), T_RCD);  // A12 high for BL8
        push_exp(EV_CMD, build_cmd(ddr3_pkg::PRE, e.ba, {4'b0000, e.a10, 10'h000}),
                 (r.is_write ? WL : RL) + BL);
        push_exp(EV_ACC_ACK, ddr3_pkg::DESELECT, 1);
        acc     <= r;
        acc_req <= 1'b1;
    endtask

    task automatic finish_access(input entry_t e);
        do @(negedge CLK); while (!acc_ack);
        if (e.kind != K_WR) check_burst(rdata, tbl[e.src].wdata, "read data");
        @(posedge CLK);
        acc_req <= 1'b0;
        do @(negedge CLK); while (acc_ack);
    endtask

    task automatic run_refresh();
        push_exp(EV_CMD, build_cmd(ddr3_pkg::REF, 3'd0, 15'h0000), 1);
        push_exp(EV_REF_ACK, ddr3_pkg::DESELECT, T_RFC + 1);
        @(posedge CLK);
        ref_req <= 1'b1;
    endtask

    task automatic end_refresh();
        do @(negedge CLK); while (!ref_ack);
        @(posedge CLK);
        ref_req <= 1'b0;
        do @(negedge CLK); while (ref_ack);  // Four-phase release
    endtask

    ////////////////////
    // Stimulus table and main flow
    initial begin
        rst       = 1'b1;
        acc_req   = 1'b0;
        ref_req   = 1'b0;
        acc       = '0;
        dq_in     = '0;
        cur_write = 1'b0;
        cur_wdata = '0;
        rd_evt    = 1'b0;
        acc_req_q = 1'b0;
        ref_req_q = 1'b0;
        acc_ack_q = 1'b0;
        ref_ack_q = 1'b0;
        tbl[0] = '{K_REF, 3'd0, 15'h0000, 10'h000, 1'b0, 64'h0, 0};
        tbl[1] = '{K_WR,  3'd1, 15'h1234, 10'h010, 1'b0, 64'h8877_6655_4433_2211, 0};
        tbl[2] = '{K_WR,  3'd5, 15'h7abc, 10'h3f8, 1'b1, 64'h0, 0};
        tbl[3] = '{K_RD,  3'd1, 15'h1234, 10'h010, 1'b0, 64'h0, 1};
        tbl[4] = '{K_WR,  3'd2, 15'h0042, 10'h100, 1'b0, 64'h0, 0};
        tbl[5] = '{K_RD,  3'd5, 15'h7abc, 10'h3f8, 1'b0, 64'h0, 2};
        tbl[6] = '{K_ARB, 3'd2, 15'h0042, 10'h100, 1'b1, 64'h0, 4};
        tbl[7] = '{K_RD,  3'd1, 15'h1234, 10'h010, 1'b1, 64'h0, 1};
        foreach (tbl[i]) begin
            if (tbl[i].kind == K_WR && tbl[i].wdata == '0) begin
                tbl[i].wdata = {$random(seed), $random(seed)};
            end
        end
        push_exp(EV_CMD, build_cmd(ddr3_pkg::ZQCL, 3'd0, 15'h0400), -1);
        repeat (16) @(posedge CLK);
        rst <= 1'b0;
        do @(negedge CLK); while (exp_q.size() != 0);  // ZQCL first and alone
        check_gap(rn_low, RESET_CYCLES, "cycles with DRAM reset low");
        for (int i = 0; i < 8; i++) begin
            case (tbl[i].kind)
                K_REF: begin
                    run_refresh();
                    end_refresh();
                end
                K_ARB: begin
                    run_refresh();
                    start_access(tbl[i], -1);  // Same edge as ref_req
                    end_refresh();
                    finish_access(tbl[i]);
                end
                default: begin
                    @(posedge CLK);
                    start_access(tbl[i], 1);
                    finish_access(tbl[i]);
                end
            endcase
        end
        repeat (4) @(negedge CLK);
        if (exp_q.size() != 0) begin
            stop_fail("Expected commands never appeared on the bus");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- filelist.f
hw/ddr3_pkg.sv
hw/ddr3_init_seq.sv
hw/ddr3_access_fsm.sv
hw/ddr3_dq_burst.sv
hw/ddr3_seq_top.sv
test/ddr3_seq_tb.sv

//--- Makefile
TOP = ddr3_seq_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
